/* project.f */
+incdir+verif
source/hl2_ctrl_pkg.sv
source/cmd_receiver.sv
source/cmd_regs.sv
source/timebase.sv
source/tr_sequencer.sv
source/resp_builder.sv
source/hl2_ctrl_core.sv
verif/tb_hl2_ctrl_core.sv

/* source/cmd_receiver.sv */
// command receiver
// synchronizes the downstream command toggle into clk_ctrl and turns each
// change into a one-cycle strobe with the captured command

`timescale 1ns/1ns
`default_nettype none

module cmd_receiver (
  input  wire                      clk_ctrl,
  input  wire                      reset_i,
  input  wire                      cmd_cnt_i,
  input  wire hl2_ctrl_pkg::cmd_addr_t cmd_addr_i,
  input  wire hl2_ctrl_pkg::cmd_data_t cmd_data_i,
  input  wire                      cmd_requires_resp_i,
  output logic                     cmd_strobe_o,
  output hl2_ctrl_pkg::cmd_t       cmd_o
);

  // toggle synchronizer and edge register
  logic cnt_meta;
  logic cnt_sync;
  logic cnt_last;
  logic toggle_seen;

  always_ff @(posedge clk_ctrl) begin
    cnt_meta <= cmd_cnt_i;
    cnt_sync <= cnt_meta;
  end

  // either direction of the toggle is one new command
  assign toggle_seen = cnt_sync ^ cnt_last;

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      // track the toggle so leaving reset gives no strobe
      cnt_last     <= cnt_sync;
      cmd_strobe_o <= 1'b0;
    end else begin
      cnt_last     <= cnt_sync;
      cmd_strobe_o <= toggle_seen;
    end
  end

  // sender holds address and data stable around the toggle
  always_ff @(posedge clk_ctrl) begin
    if (toggle_seen) begin
      cmd_o.addr          <= cmd_addr_i;
      cmd_o.data          <= cmd_data_i;
      cmd_o.requires_resp <= cmd_requires_resp_i;
    end
  end

endmodule

`default_nettype wire

/* source/cmd_regs.sv */
// command registers
// decodes command addresses into the held run, ptt, pa and hang time
// settings used by the t/r sequencer and the response builder

`timescale 1ns/1ns
`default_nettype none

module cmd_regs (
  input  wire                     clk_ctrl,
  input  wire                     reset_i,
  input  wire                     cmd_strobe_i,
  input  wire hl2_ctrl_pkg::cmd_t cmd_i,
  output hl2_ctrl_pkg::tr_cfg_t   cfg_o,
  output logic                    io_led_run_o
);

  hl2_ctrl_pkg::tr_cfg_t cfg_q;

  ////////////////////////////////////////////////////////////////////////////
  // address decode

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      cfg_q <= '0;
    end else if (cmd_strobe_i) begin
      case (cmd_i.addr)
        hl2_ctrl_pkg::ADDR_GENERAL: begin
          cfg_q.run <= cmd_i.data[hl2_ctrl_pkg::GEN_RUN_BIT];
          cfg_q.ptt <= cmd_i.data[hl2_ctrl_pkg::GEN_PTT_BIT];
        end
        hl2_ctrl_pkg::ADDR_PA_CTRL: begin
          cfg_q.pa_on     <= cmd_i.data[hl2_ctrl_pkg::PA_ON_BIT];
          cfg_q.ext_tr_en <= cmd_i.data[hl2_ctrl_pkg::EXT_TR_EN_BIT];
        end
        hl2_ctrl_pkg::ADDR_TR_HANG: begin
          cfg_q.hang_ms <=
            cmd_i.data[hl2_ctrl_pkg::HANG_MS_LSB +: $bits(hl2_ctrl_pkg::hang_ms_t)];
        end
        default: begin
          // addresses owned by other blocks
          cfg_q <= cfg_q;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs

  assign cfg_o        = cfg_q;
  // run led shows the held run bit
  assign io_led_run_o = cfg_q.run;

endmodule

`default_nettype wire

/* source/hl2_ctrl_core.sv */
// hl2 control core
// control clock domain of the transceiver: command receive and decode,
// t/r sequencing with hang time and inhibit, and response generation

`timescale 1ns/1ns
`default_nettype none

module hl2_ctrl_core (
  input  wire                          clk_ctrl,
  input  wire                          reset_i,
  // downstream commands
  input  wire                          cmd_cnt_i,
  input  wire hl2_ctrl_pkg::cmd_addr_t cmd_addr_i,
  input  wire hl2_ctrl_pkg::cmd_data_t cmd_data_i,
  input  wire                          cmd_requires_resp_i,
  // asynchronous hardware inhibit
  input  wire                          io_tx_inhibit_i,
  // upstream response
  output hl2_ctrl_pkg::resp_t          resp_o,
  output logic                         resp_valid_o,
  // leds and pa switching
  output logic                         io_led_run_o,
  output logic                         io_led_tx_o,
  output logic                         pa_inttr_o,
  output logic                         pa_exttr_o
);

  logic                  cmd_strobe;
  hl2_ctrl_pkg::cmd_t    cmd;
  hl2_ctrl_pkg::tr_cfg_t cfg;
  logic                  msec_strobe;
  logic                  tx_on;

  ////////////////////////////////////////////////////////////////////////////
  // command path

  cmd_receiver i_cmd_receiver (
    .clk_ctrl            (clk_ctrl),
    .reset_i             (reset_i),
    .cmd_cnt_i           (cmd_cnt_i),
    .cmd_addr_i          (cmd_addr_i),
    .cmd_data_i          (cmd_data_i),
    .cmd_requires_resp_i (cmd_requires_resp_i),
    .cmd_strobe_o        (cmd_strobe),
    .cmd_o               (cmd)
  );

  cmd_regs i_cmd_regs (
    .clk_ctrl     (clk_ctrl),
    .reset_i      (reset_i),
    .cmd_strobe_i (cmd_strobe),
    .cmd_i        (cmd),
    .cfg_o        (cfg),
    .io_led_run_o (io_led_run_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // t/r switching

  timebase i_timebase (
    .clk_ctrl      (clk_ctrl),
    .reset_i       (reset_i),
    .msec_strobe_o (msec_strobe)
  );

  tr_sequencer i_tr_sequencer (
    .clk_ctrl        (clk_ctrl),
    .reset_i         (reset_i),
    .cfg_i           (cfg),
    .msec_strobe_i   (msec_strobe),
    .io_tx_inhibit_i (io_tx_inhibit_i),
    .tx_on_o         (tx_on),
    .pa_inttr_o      (pa_inttr_o),
    .pa_exttr_o      (pa_exttr_o)
  );

  assign io_led_tx_o = tx_on;

  ////////////////////////////////////////////////////////////////////////////
  // response

  resp_builder i_resp_builder (
    .clk_ctrl     (clk_ctrl),
    .reset_i      (reset_i),
    .cmd_strobe_i (cmd_strobe),
    .cmd_i        (cmd),
    .tx_on_i      (tx_on),
    .run_i        (cfg.run),
    .resp_o       (resp_o),
    .resp_valid_o (resp_valid_o)
  );

endmodule

`default_nettype wire

/* source/hl2_ctrl_pkg.sv */
// hl2 control package
// command, configuration and response types plus the constants shared by
// the control clock domain blocks of the transceiver core

`default_nettype none

package hl2_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // plain vector types

  // downstream command register address
  typedef logic [5:0]  cmd_addr_t;
  // downstream command payload
  typedef logic [31:0] cmd_data_t;
  // upstream response word
  typedef logic [39:0] resp_t;
  // t/r hang time in milliseconds
  typedef logic [7:0]  hang_ms_t;
  // firmware version fields
  typedef logic [7:0]  version_t;
  // timebase counters
  typedef logic [9:0]  qmsec_cnt_t;
  typedef logic [1:0]  msec_div_t;

  ////////////////////////////////////////////////////////////////////////////
  // structs and enums

  // one captured command of 39 bits
  typedef struct packed {
    cmd_addr_t addr;
    cmd_data_t data;
    logic      requires_resp;
  } cmd_t;

  // held transmit/receive configuration of 12 bits
  typedef struct packed {
    logic     run;
    logic     ptt;
    logic     pa_on;
    logic     ext_tr_en;
    hang_ms_t hang_ms;
  } tr_cfg_t;

  // t/r sequencer states
  typedef enum logic [1:0] {
    TR_RX   = 2'd0,
    TR_TX   = 2'd1,
    TR_HANG = 2'd2
  } tr_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // command addresses and payload fields

  localparam cmd_addr_t ADDR_GENERAL  = 6'h00;
  localparam cmd_addr_t ADDR_PA_CTRL  = 6'h09;
  localparam cmd_addr_t ADDR_TR_HANG  = 6'h17;

  // general register
  localparam int GEN_RUN_BIT   = 0;
  localparam int GEN_PTT_BIT   = 1;
  // pa control register
  localparam int PA_ON_BIT     = 20;
  localparam int EXT_TR_EN_BIT = 19;
  // lsb of the hang_ms field in the hang register
  localparam int HANG_MS_LSB   = 0;

  ////////////////////////////////////////////////////////////////////////////
  // version and timing

  localparam version_t VERSION_MAJOR = 8'd71;
  localparam version_t VERSION_MINOR = 8'd2;

  // 2.5 MHz control clock
  localparam int QMSEC_CYCLES   = 625;
  localparam int QMSEC_PER_MSEC = 4;

endpackage

`default_nettype wire

/* source/resp_builder.sv */
// response builder
// assembles the 40-bit upstream response word for commands that request
// a reply and marks it with a one-cycle valid

`timescale 1ns/1ns
`default_nettype none

module resp_builder (
  input  wire                     clk_ctrl,
  input  wire                     reset_i,
  input  wire                     cmd_strobe_i,
  input  wire hl2_ctrl_pkg::cmd_t cmd_i,
  input  wire                     tx_on_i,
  input  wire                     run_i,
  output hl2_ctrl_pkg::resp_t     resp_o,
  output logic                    resp_valid_o
);

  logic resp_load;

  assign resp_load = cmd_strobe_i & cmd_i.requires_resp;

  // word layout from the msb down
  //   addr, tx_on, run, version major, version minor, data[15:0]
  // tx_on and run are the values before this command takes effect
  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      resp_o <= '0;
    end else if (resp_load) begin
      resp_o <= {cmd_i.addr,
                 tx_on_i,
                 run_i,
                 hl2_ctrl_pkg::VERSION_MAJOR,
                 hl2_ctrl_pkg::VERSION_MINOR,
                 cmd_i.data[15:0]};
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= resp_load;
    end
  end

endmodule

`default_nettype wire

/* source/timebase.sv */
// timebase
// divides clk_ctrl down to quarter-millisecond ticks and a
// one-cycle millisecond strobe

`timescale 1ns/1ns
`default_nettype none

module timebase (
  input  wire  clk_ctrl,
  input  wire  reset_i,
  output logic msec_strobe_o
);

  hl2_ctrl_pkg::qmsec_cnt_t qmsec_cnt;
  hl2_ctrl_pkg::msec_div_t  msec_div;
  logic                     qmsec_tick;

  // last cycle of each quarter millisecond
  assign qmsec_tick =
    (qmsec_cnt == hl2_ctrl_pkg::qmsec_cnt_t'(hl2_ctrl_pkg::QMSEC_CYCLES - 1));

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      qmsec_cnt     <= '0;
      msec_div      <= '0;
      msec_strobe_o <= 1'b0;
    end else begin
      msec_strobe_o <= 1'b0;
      if (qmsec_tick) begin
        qmsec_cnt <= '0;
        // four quarters make one millisecond
        if (msec_div == hl2_ctrl_pkg::msec_div_t'(hl2_ctrl_pkg::QMSEC_PER_MSEC - 1)) begin
          msec_div      <= '0;
          msec_strobe_o <= 1'b1;
        end else begin
          msec_div <= msec_div + 1'b1;
        end
      end else begin
        qmsec_cnt <= qmsec_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/tr_sequencer.sv */
// t/r sequencer
// drives transmit enable from ptt and the hardware inhibit, and holds
// the internal and external t/r switches for a hang time after transmit

`timescale 1ns/1ns
`default_nettype none

module tr_sequencer (
  input  wire                        clk_ctrl,
  input  wire                        reset_i,
  input  wire hl2_ctrl_pkg::tr_cfg_t cfg_i,
  input  wire                        msec_strobe_i,
  input  wire                        io_tx_inhibit_i,
  output logic                       tx_on_o,
  output logic                       pa_inttr_o,
  output logic                       pa_exttr_o
);

  logic                   inhibit_meta;
  logic                   inhibit_sync;
  logic                   tx_on_q;
  logic                   tr_active;
  hl2_ctrl_pkg::tr_state_t state_q;
  hl2_ctrl_pkg::hang_ms_t  hang_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // inhibit synchronizer

  always_ff @(posedge clk_ctrl) begin
    inhibit_meta <= io_tx_inhibit_i;
    inhibit_sync <= inhibit_meta;
  end

  ////////////////////////////////////////////////////////////////////////////
  // transmit enable

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      tx_on_q <= 1'b0;
    end else begin
      tx_on_q <= cfg_i.ptt & ~inhibit_sync;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // t/r state machine

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      state_q  <= hl2_ctrl_pkg::TR_RX;
      hang_cnt <= '0;
    end else begin
      case (state_q)
        hl2_ctrl_pkg::TR_RX: begin
          if (tx_on_q) begin
            state_q <= hl2_ctrl_pkg::TR_TX;
          end
        end
        hl2_ctrl_pkg::TR_TX: begin
          if (!tx_on_q) begin
            state_q  <= hl2_ctrl_pkg::TR_HANG;
            hang_cnt <= cfg_i.hang_ms;
          end
        end
        hl2_ctrl_pkg::TR_HANG: begin
          // new ptt cancels the hang
          if (tx_on_q) begin
            state_q <= hl2_ctrl_pkg::TR_TX;
          end else if (hang_cnt == '0) begin
            state_q <= hl2_ctrl_pkg::TR_RX;
          end else if (msec_strobe_i) begin
            hang_cnt <= hang_cnt - 1'b1;
          end
        end
        default: begin
          state_q <= hl2_ctrl_pkg::TR_RX;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs

  assign tr_active  = (state_q != hl2_ctrl_pkg::TR_RX);
  assign tx_on_o    = tx_on_q;
  assign pa_inttr_o = tr_active & cfg_i.pa_on;
  assign pa_exttr_o = tr_active & cfg_i.ext_tr_en;

endmodule

`default_nettype wire

/* verif/ctrl_model.svh */
// control core reference model
// held configuration, response word layout and expected t/r switching,
// included inside the testbench module

`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

hl2_ctrl_pkg::tr_cfg_t   model_cfg;
hl2_ctrl_pkg::tr_state_t model_tr_state;
logic                    model_inhibit;

// transmit enable follows ptt unless inhibited
function automatic logic model_tx_on();
  return model_cfg.ptt & ~model_inhibit;
endfunction

// response word from the msb down is addr, tx_on, run, major, minor, data[15:0]
function automatic hl2_ctrl_pkg::resp_t model_resp(input hl2_ctrl_pkg::cmd_addr_t addr,
                                                   input hl2_ctrl_pkg::cmd_data_t data);
  return {addr, model_tx_on(), model_cfg.run, hl2_ctrl_pkg::VERSION_MAJOR,
          hl2_ctrl_pkg::VERSION_MINOR, data[15:0]};
endfunction

// register decode where unknown addresses keep the configuration
function automatic void model_apply(input hl2_ctrl_pkg::cmd_addr_t addr,
                                    input hl2_ctrl_pkg::cmd_data_t data);
  if (addr == hl2_ctrl_pkg::ADDR_GENERAL) begin
    model_cfg.run = data[hl2_ctrl_pkg::GEN_RUN_BIT];
    model_cfg.ptt = data[hl2_ctrl_pkg::GEN_PTT_BIT];
  end else if (addr == hl2_ctrl_pkg::ADDR_PA_CTRL) begin
    model_cfg.pa_on     = data[hl2_ctrl_pkg::PA_ON_BIT];
    model_cfg.ext_tr_en = data[hl2_ctrl_pkg::EXT_TR_EN_BIT];
  end else if (addr == hl2_ctrl_pkg::ADDR_TR_HANG) begin
    model_cfg.hang_ms = data[7:0];
  end
  if (model_tx_on()) begin
    model_tr_state = hl2_ctrl_pkg::TR_TX;
  end else if (model_tr_state == hl2_ctrl_pkg::TR_TX) begin
    model_tr_state = hl2_ctrl_pkg::TR_HANG;
  end
endfunction

// t/r switches are active outside receive
function automatic logic model_inttr();
  return (model_tr_state != hl2_ctrl_pkg::TR_RX) & model_cfg.pa_on;
endfunction

function automatic logic model_exttr();
  return (model_tr_state != hl2_ctrl_pkg::TR_RX) & model_cfg.ext_tr_en;
endfunction

`endif

/* verif/tb_hl2_ctrl_core.sv */
// hl2 control core testbench
// random commands against a reference model, plus t/r hang and inhibit runs

`timescale 1ns/1ns
`default_nettype none

module tb_hl2_ctrl_core;

  localparam int SEED        = 73;
  localparam int NUM_CMDS    = 40;
  localparam int CMD_SPACING = 8;
  localparam int MSEC_CYCLES = hl2_ctrl_pkg::QMSEC_CYCLES * hl2_ctrl_pkg::QMSEC_PER_MSEC;

  logic                    clk_ctrl;
  logic                    reset_i;
  logic                    cmd_cnt_i;
  hl2_ctrl_pkg::cmd_addr_t cmd_addr_i;
  hl2_ctrl_pkg::cmd_data_t cmd_data_i;
  logic                    cmd_requires_resp_i;
  logic                    io_tx_inhibit_i;
  hl2_ctrl_pkg::resp_t     resp_o;
  logic                    resp_valid_o;
  logic                    io_led_run_o;
  logic                    io_led_tx_o;
  logic                    pa_inttr_o;
  logic                    pa_exttr_o;
  int                      mismatch_count;
  int                      failure_count;
  int                      idx;
  int                      waited;
  hl2_ctrl_pkg::cmd_data_t data;
  int                      hang;

  `include "ctrl_model.svh"

  hl2_ctrl_core i_hl2_ctrl_core (
    .clk_ctrl            (clk_ctrl),
    .reset_i             (reset_i),
    .cmd_cnt_i           (cmd_cnt_i),
    .cmd_addr_i          (cmd_addr_i),
    .cmd_data_i          (cmd_data_i),
    .cmd_requires_resp_i (cmd_requires_resp_i),
    .io_tx_inhibit_i     (io_tx_inhibit_i),
    .resp_o              (resp_o),
    .resp_valid_o        (resp_valid_o),
    .io_led_run_o        (io_led_run_o),
    .io_led_tx_o         (io_led_tx_o),
    .pa_inttr_o          (pa_inttr_o),
    .pa_exttr_o          (pa_exttr_o)
  );

  always #2 clk_ctrl = ~clk_ctrl;

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("failure at %0t ns: %s", $time, what);
    failure_count++;
  endtask

  function automatic hl2_ctrl_pkg::cmd_addr_t pick_addr();
    case ($urandom_range(0, 3))
      0: return hl2_ctrl_pkg::ADDR_GENERAL;
      1: return hl2_ctrl_pkg::ADDR_PA_CTRL;
      2: return hl2_ctrl_pkg::ADDR_TR_HANG;
      default: return hl2_ctrl_pkg::cmd_addr_t'($urandom);
    endcase
  endfunction

  // one command per toggle and a watch over the full spacing window
  task automatic send_cmd(input hl2_ctrl_pkg::cmd_addr_t addr,
                          input hl2_ctrl_pkg::cmd_data_t cmd_data, input logic req);
    hl2_ctrl_pkg::resp_t exp_resp;
    int                  pulses;
    int                  i;
    exp_resp = model_resp(addr, cmd_data);
    pulses   = 0;
    @(negedge clk_ctrl);
    cmd_addr_i          = addr;
    cmd_data_i          = cmd_data;
    cmd_requires_resp_i = req;
    cmd_cnt_i           = ~cmd_cnt_i;
    for (i = 0; i < CMD_SPACING; i++) begin
      @(negedge clk_ctrl);
      if (resp_valid_o) begin
        pulses++;
        check_value("resp_o", exp_resp, resp_o);
      end
    end
    model_apply(addr, cmd_data);
    if (req && pulses != 1) begin
      report_failure($sformatf("expected one response for address 0x%0h, saw %0d",
                               addr, pulses));
    end else if (!req && pulses != 0) begin
      report_failure($sformatf("response without request for address 0x%0h", addr));
    end
    check_value("io_led_run_o", model_cfg.run, io_led_run_o);
    check_value("io_led_tx_o", model_tx_on(), io_led_tx_o);
  endtask

  // counts how long the t/r switches stay on after transmit ends
  task automatic measure_hang(input int hang_ms);
    int cycles;
    int lo;
    int hi;
    cycles = 0;
    lo     = (hang_ms - 1) * MSEC_CYCLES - CMD_SPACING;
    hi     = hang_ms * MSEC_CYCLES;
    while ((pa_inttr_o || pa_exttr_o) && cycles <= hi + 16) begin
      @(negedge clk_ctrl);
      cycles++;
    end
    if ((model_cfg.pa_on || model_cfg.ext_tr_en) && (cycles < lo || cycles > hi)) begin
      report_failure($sformatf("t/r hang lasted %0d cycles, expected %0d to %0d",
                               cycles, lo, hi));
    end
    model_tr_state = hl2_ctrl_pkg::TR_RX;
    check_value("pa_inttr_o", model_inttr(), pa_inttr_o);
    check_value("pa_exttr_o", model_exttr(), pa_exttr_o);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    clk_ctrl            = 1'b0;
    reset_i             = 1'b1;
    cmd_cnt_i           = 1'b0;
    cmd_addr_i          = '0;
    cmd_data_i          = '0;
    cmd_requires_resp_i = 1'b0;
    io_tx_inhibit_i     = 1'b0;
    mismatch_count      = 0;
    failure_count       = 0;
    model_cfg           = '0;
    model_tr_state      = hl2_ctrl_pkg::TR_RX;
    model_inhibit       = 1'b0;
    void'($urandom(SEED));
    repeat (4) @(negedge clk_ctrl);
    reset_i = 1'b0;

    // quiet after reset
    for (idx = 0; idx < 20; idx++) begin
      @(negedge clk_ctrl);
      check_value("resp_valid_o", 1'b0, resp_valid_o);
      check_value("resp_o", '0, resp_o);
      check_value("io_led_run_o", 1'b0, io_led_run_o);
      check_value("io_led_tx_o", 1'b0, io_led_tx_o);
      check_value("pa_inttr_o", 1'b0, pa_inttr_o);
      check_value("pa_exttr_o", 1'b0, pa_exttr_o);
    end

    // random decode and responses
    for (idx = 0; idx < NUM_CMDS; idx++) begin
      send_cmd(pick_addr(), $urandom, 1'($urandom_range(0, 1)));
    end

    // t/r switching with a short hang
    for (idx = 0; idx < 4; idx++) begin
      hang = $urandom_range(1, 3);
      send_cmd(hl2_ctrl_pkg::ADDR_PA_CTRL, $urandom, 1'($urandom_range(0, 1)));
      send_cmd(hl2_ctrl_pkg::ADDR_TR_HANG, {24'($urandom), 8'(hang)}, 1'b0);
      data = $urandom;
      data[hl2_ctrl_pkg::GEN_PTT_BIT] = 1'b1;
      send_cmd(hl2_ctrl_pkg::ADDR_GENERAL, data, 1'b1);
      check_value("pa_inttr_o", model_inttr(), pa_inttr_o);
      check_value("pa_exttr_o", model_exttr(), pa_exttr_o);
      data[hl2_ctrl_pkg::GEN_PTT_BIT] = 1'b0;
      send_cmd(hl2_ctrl_pkg::ADDR_GENERAL, data, 1'b1);
      measure_hang(hang);
    end

    // inhibit overrides ptt
    data = $urandom;
    data[hl2_ctrl_pkg::GEN_PTT_BIT] = 1'b1;
    send_cmd(hl2_ctrl_pkg::ADDR_GENERAL, data, 1'b0);
    @(negedge clk_ctrl);
    io_tx_inhibit_i = 1'b1;
    model_inhibit   = 1'b1;
    waited          = 0;
    while (io_led_tx_o && waited < 5) begin
      @(negedge clk_ctrl);
      waited++;
    end
    if (io_led_tx_o) begin
      report_failure("transmit enable still high 5 cycles after inhibit");
    end
    send_cmd(hl2_ctrl_pkg::ADDR_GENERAL, data, 1'b1);
    for (idx = 0; idx < 20; idx++) begin
      @(negedge clk_ctrl);
      check_value("io_led_tx_o", 1'b0, io_led_tx_o);
    end
    io_tx_inhibit_i = 1'b0;
    model_inhibit   = 1'b0;
    model_tr_state  = hl2_ctrl_pkg::TR_TX;
    waited          = 0;
    while (!io_led_tx_o && waited < 5) begin
      @(negedge clk_ctrl);
      waited++;
    end
    if (!io_led_tx_o) begin
      report_failure("transmit enable did not return after inhibit fell");
    end
    data[hl2_ctrl_pkg::GEN_PTT_BIT] = 1'b0;
    send_cmd(hl2_ctrl_pkg::ADDR_GENERAL, data, 1'b0);
    measure_hang(int'(model_cfg.hang_ms));

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
